//--- icache_defs.svh
// ----------------------------------------
// Instruction cache geometry
// Field widths of the word address and the line count
// ----------------------------------------
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Word address is tag, index, offset
`define ICACHE_TAG_WIDTH    3   // Upper address bits
`define ICACHE_INDEX_WIDTH  5   // Selects one line
`define ICACHE_OFFSET_WIDTH 2   // Word within a line

`define ICACHE_DATA_WIDTH   32  // Bits per word

// One line per index value
`define ICACHE_LINES        (1 << `ICACHE_INDEX_WIDTH)

`endif

//--- ICachePkg.sv
// ----------------------------------------
// Instruction cache types
// Address fields, bus request and controller states
// ----------------------------------------
`include "icache_defs.svh"

package ICachePkg;

    typedef logic [`ICACHE_TAG_WIDTH-1:0]    Tag;
    typedef logic [`ICACHE_INDEX_WIDTH-1:0]  Index;
    typedef logic [`ICACHE_OFFSET_WIDTH-1:0] Offset;
    typedef logic [`ICACHE_DATA_WIDTH-1:0]   Word;

    // Full word address, tag in the top bits
    typedef logic [`ICACHE_TAG_WIDTH + `ICACHE_INDEX_WIDTH + `ICACHE_OFFSET_WIDTH - 1:0] Address;

    typedef struct packed {
        Tag    tag;     // Compared against stored tag
        Index  index;   // Line select
        Offset offset;  // Word select
    } Access;

    // Master side of a read-only Wishbone link
    typedef struct packed {
        logic   cyc;
        logic   stb;
        Address adr;
    } WbRequest;

    typedef enum logic [1:0] {
        Reset,   // One cycle after reset
        Clear,   // Valid bits cleared line by line
        Lookup,  // Serving requests
        Read     // Line refill from memory
    } State;

endpackage

//--- ICacheController.sv
// ----------------------------------------
// Instruction cache controller
// Clears the tags after reset, answers lookups, runs refills
// ----------------------------------------
`timescale 1ns/1ps
`include "icache_defs.svh"

module ICacheController (
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_rd,       // Read request
    input  ICachePkg::Address i_address,  // Requested word
    input  logic              i_hit,      // From storage
    input  logic              i_done,     // Word arrived from memory
    output ICachePkg::Access  o_access,   // Position for storage and bus
    output logic              o_write,    // Store refill word
    output logic              o_clear,    // Drop valid bit of a line
    output logic              o_fetch,    // Memory port request
    output logic              o_hit,
    output logic              o_busy
);

    ICachePkg::State  state;
    ICachePkg::State  nextState;
    ICachePkg::Access request;     // Address split into fields
    ICachePkg::Tag    tag;         // Tag of line under refill
    ICachePkg::Tag    nextTag;
    ICachePkg::Index  index;       // Clear counter, then refill line
    ICachePkg::Index  nextIndex;
    ICachePkg::Offset offset;      // Word being refilled
    ICachePkg::Offset nextOffset;

    assign request = ICachePkg::Access'(i_address);

    // ----------------------------------------
    // Next state and outputs
    // ----------------------------------------
    always_comb begin
        o_access   = request;  // Lookup follows the CPU
        o_write    = 1'b0;
        o_clear    = 1'b0;
        o_fetch    = 1'b0;
        o_hit      = 1'b0;
        o_busy     = 1'b1;
        nextState  = state;
        nextTag    = tag;
        nextIndex  = index;
        nextOffset = offset;

        case (state)
            ICachePkg::Reset: begin
                nextIndex = ICachePkg::Index'(0);
                nextState = ICachePkg::Clear;
            end

            ICachePkg::Clear: begin
                o_access.index = index;  // Line being invalidated
                o_clear        = 1'b1;
                nextIndex      = ICachePkg::Index'(index + 1'b1);
                if (index == ICachePkg::Index'(`ICACHE_LINES - 1))
                    nextState = ICachePkg::Lookup;
            end

            ICachePkg::Lookup: begin
                o_hit  = i_hit;
                o_busy = 1'b0;
                if (i_rd && !i_hit) begin
                    // Miss, refill starts at word 0
                    nextTag    = request.tag;
                    nextIndex  = request.index;
                    nextOffset = ICachePkg::Offset'(0);
                    nextState  = ICachePkg::Read;
                end
            end

            ICachePkg::Read: begin
                o_access = {tag, index, offset};
                o_fetch  = 1'b1;  // Held for the whole refill
                if (i_done) begin
                    o_write    = 1'b1;  // Word lands this cycle
                    nextOffset = ICachePkg::Offset'(offset + 1'b1);
                    if (offset == ICachePkg::Offset'('1))
                        nextState = ICachePkg::Lookup;  // Line complete
                end
            end

            default: nextState = ICachePkg::Reset;
        endcase
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state  <= ICachePkg::Reset;
            tag    <= ICachePkg::Tag'(0);
            index  <= ICachePkg::Index'(0);
            offset <= ICachePkg::Offset'(0);
        end else begin
            state  <= nextState;
            tag    <= nextTag;
            index  <= nextIndex;
            offset <= nextOffset;
        end
    end

    // Memory port answers only an open fetch
    assert property (@(posedge i_clock) disable iff (i_reset) i_done |-> o_fetch);

    // CPU keeps its request steady for the whole refill
    assert property (@(posedge i_clock) disable iff (i_reset)
        (state == ICachePkg::Read) |-> (i_rd && $stable(i_address)));

endmodule

//--- ICacheStorage.sv
// ----------------------------------------
// Instruction cache storage
// Valid bits, tags and data words with hit check
// ----------------------------------------
`timescale 1ns/1ps
`include "icache_defs.svh"

module ICacheStorage (
    input  logic             i_clock,
    input  logic             i_reset,
    input  ICachePkg::Access i_access,  // Line and word addressed
    input  logic             i_write,   // Store i_data
    input  logic             i_clear,   // Invalidate line
    input  ICachePkg::Word   i_data,    // Refill word
    output logic             o_hit,
    output ICachePkg::Word   o_data
);

    // Four words per line
    localparam int WordCount = `ICACHE_LINES << `ICACHE_OFFSET_WIDTH;

    logic [`ICACHE_LINES-1:0] valid;              // One bit per line
    ICachePkg::Tag            tags [`ICACHE_LINES];
    ICachePkg::Word           words [WordCount];

    logic [`ICACHE_INDEX_WIDTH + `ICACHE_OFFSET_WIDTH - 1:0] wordAddress;
    logic lastWord;  // Final word of a line

    assign wordAddress = {i_access.index, i_access.offset};
    assign lastWord    = (i_access.offset == ICachePkg::Offset'('1));

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset)
            valid <= '0;
        else if (i_clear)
            valid[i_access.index] <= 1'b0;
        else if (i_write && lastWord)
            valid[i_access.index] <= 1'b1;  // Whole line present now
    end

    // Tag goes in with the last word only
    always_ff @(posedge i_clock) begin
        if (i_write && lastWord)
            tags[i_access.index] <= i_access.tag;
    end

    // Data array
    always_ff @(posedge i_clock) begin
        if (i_write)
            words[wordAddress] <= i_data;
    end

    // ----------------------------------------
    // Lookup
    // ----------------------------------------
    assign o_hit  = valid[i_access.index] && (tags[i_access.index] == i_access.tag);
    assign o_data = words[wordAddress];  // Same-cycle read

    // Clear sweep and refill never share a cycle
    assert property (@(posedge i_clock) disable iff (i_reset) !(i_write && i_clear));

endmodule

//--- ICacheMemPort.sv
// ----------------------------------------
// Wishbone classic read master
// One single-word transfer per fetch
// ----------------------------------------
`timescale 1ns/1ps

module ICacheMemPort (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_fetch,   // Word wanted
    input  ICachePkg::Access    i_access,  // Word position
    output ICachePkg::WbRequest o_wb,
    input  ICachePkg::Word      i_wbData,
    input  logic                i_wbAck,
    output ICachePkg::Word      o_word,    // Valid with o_done
    output logic                o_done     // Ack cycle
);

    typedef enum logic {
        PortIdle,  // No transfer open
        PortWait   // Waiting for ack
    } PortState;

    PortState          state;
    PortState          nextState;
    logic              ackSeen;  // Ack in previous cycle
    logic              start;    // Transfer opens this cycle
    logic              active;   // Bus cycle in progress
    ICachePkg::Address heldAdr;  // Address kept while waiting

    // Skip one cycle after an ack so stb drops
    assign start  = (state == PortIdle) && i_fetch && !ackSeen;
    assign active = start || (state == PortWait);

    always_comb begin
        o_wb.cyc  = active;
        o_wb.stb  = active;
        o_wb.adr  = (state == PortWait) ? heldAdr : ICachePkg::Address'(i_access);
        nextState = state;
        if (active)
            nextState = i_wbAck ? PortIdle : PortWait;  // Slave may stall
    end

    assign o_done = active && i_wbAck;
    assign o_word = i_wbData;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= PortIdle;
            ackSeen <= 1'b0;
        end else begin
            state   <= nextState;
            ackSeen <= o_done;
        end
    end

    always_ff @(posedge i_clock) begin
        if (start)
            heldAdr <= ICachePkg::Address'(i_access);
    end

    // Request held with a stable address until the slave acks
    assert property (@(posedge i_clock) disable iff (i_reset)
        (o_wb.stb && !i_wbAck) |=> (o_wb.cyc && o_wb.stb && $stable(o_wb.adr)));

    // Bus released for one cycle after every ack
    assert property (@(posedge i_clock) disable iff (i_reset) o_done |=> !o_wb.stb);

endmodule

//--- ICache.sv
// ----------------------------------------
// Direct mapped instruction cache
// ----------------------------------------
`timescale 1ns/1ps

module ICache (
    input  logic                i_clock,
    input  logic                i_reset,
    // CPU side
    input  logic                i_rd,
    input  ICachePkg::Address   i_address,
    output ICachePkg::Word      o_data,
    output logic                o_hit,
    output logic                o_busy,
    // Memory side
    output ICachePkg::WbRequest o_wb,
    input  ICachePkg::Word      i_wbData,
    input  logic                i_wbAck
);

    ICachePkg::Access access;  // Shared word position
    ICachePkg::Word   word;    // Refill data
    logic             write;
    logic             clear;
    logic             fetch;
    logic             hit;     // Raw storage hit
    logic             done;

    ICacheController controller (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rd      (i_rd),
        .i_address (i_address),
        .i_hit     (hit),
        .i_done    (done),
        .o_access  (access),
        .o_write   (write),
        .o_clear   (clear),
        .o_fetch   (fetch),
        .o_hit     (o_hit),
        .o_busy    (o_busy)
    );

    ICacheStorage storage (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_access (access),
        .i_write  (write),
        .i_clear  (clear),
        .i_data   (word),
        .o_hit    (hit),
        .o_data   (o_data)
    );

    ICacheMemPort memPort (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_fetch  (fetch),
        .i_access (access),
        .o_wb     (o_wb),
        .i_wbData (i_wbData),
        .i_wbAck  (i_wbAck),
        .o_word   (word),
        .o_done   (done)
    );

endmodule

//--- ICacheTb.sv
// ----------------------------------------
// Instruction cache testbench
// Wishbone memory model, read table and shadow tag model
// ----------------------------------------
`timescale 1ns/1ps
`include "icache_defs.svh"

module ICacheTb;

    typedef struct packed {
        ICachePkg::Access access;  // Word read by the CPU
        logic             hit;     // Expected first lookup result
    } TableEntry;

    logic                clock = 1'b0;
    logic                reset;
    logic                rd;
    ICachePkg::Address   address;
    ICachePkg::Word      data;
    logic                hit;
    logic                busy;
    ICachePkg::WbRequest wb;
    ICachePkg::Word      wbData = '0;
    logic                wbAck = 1'b0;

    // Memory model state
    integer            seed = 32'h7498;
    logic [31:0]       randomWord;
    logic [1:0]        delayNow;
    logic [1:0]        ackDelay = 2'd0;  // Wait cycles still to go
    logic              pending = 1'b0;   // Transfer seen, not yet acked
    logic              afterAck = 1'b0;  // Previous cycle was an ack
    ICachePkg::Address busAddresses [$];  // Every acked address, in order

    // Shadow of the cache contents
    logic          shadowValid [`ICACHE_LINES];
    ICachePkg::Tag shadowTag [`ICACHE_LINES];
    int            busyCycles;

    // Tag, index, offset and the expected hit of the first lookup
    TableEntry testTable [12] = '{
        '{'{3'd1, 5'd4,  2'd0}, 1'b0},  // Cold miss
        '{'{3'd1, 5'd4,  2'd1}, 1'b1},
        '{'{3'd1, 5'd4,  2'd2}, 1'b1},
        '{'{3'd1, 5'd4,  2'd3}, 1'b1},
        '{'{3'd1, 5'd4,  2'd0}, 1'b1},
        '{'{3'd5, 5'd4,  2'd2}, 1'b0},  // Same index, evicts tag 1
        '{'{3'd1, 5'd4,  2'd1}, 1'b0},  // Evicted line misses again
        '{'{3'd2, 5'd17, 2'd3}, 1'b0},
        '{'{3'd2, 5'd17, 2'd0}, 1'b1},
        '{'{3'd7, 5'd31, 2'd1}, 1'b0},
        '{'{3'd1, 5'd4,  2'd3}, 1'b1},  // Other line untouched
        '{'{3'd0, 5'd0,  2'd0}, 1'b0}
    };
    string testNames [12] = '{
        "first miss", "line word 1", "line word 2", "line word 3",
        "repeat word 0", "evict tag", "old tag again", "new index",
        "new index hit", "top index", "other line kept", "zero address"
    };

    ICache dut (
        .i_clock   (clock),
        .i_reset   (reset),
        .i_rd      (rd),
        .i_address (address),
        .o_data    (data),
        .o_hit     (hit),
        .o_busy    (busy),
        .o_wb      (wb),
        .i_wbData  (wbData),
        .i_wbAck   (wbAck)
    );

    always #50 clock = ~clock;  // 100 ns period

    // Memory contents as a function of the word address
    function automatic ICachePkg::Word memoryWord(input ICachePkg::Address wordAddress);
        ICachePkg::Word extended;
        extended = ICachePkg::Word'(wordAddress);
        return extended * 32'h9E3779B1;
    endfunction

    task automatic stopWithFailure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s expected %h actual %h", testName, expected, actual);
            stopWithFailure();
        end
    endtask

    // ----------------------------------------
    // Wishbone slave with random ack delay
    // ----------------------------------------
    always @(posedge clock) begin
        if (reset) begin
            wbAck   <= 1'b0;
            pending <= 1'b0;
        end else if (wbAck) begin
            assert (wb.cyc && wb.stb) else begin
                $display("Bus cycle closed before the ack cycle");
                stopWithFailure();
            end
            busAddresses.push_back(wb.adr);  // Ack cycle ends the transfer
            wbAck   <= 1'b0;
            pending <= 1'b0;
        end else if (wb.cyc && wb.stb) begin
            if (pending) begin
                delayNow = ackDelay;
            end else begin
                randomWord = $random(seed);
                delayNow   = randomWord[1:0];  // 0 to 3 wait cycles
            end
            if (delayNow == 2'd0) begin
                wbAck  <= 1'b1;
                wbData <= memoryWord(wb.adr);
            end else begin
                pending  <= 1'b1;
                ackDelay <= delayNow - 2'd1;
            end
        end
    end

    // Bus protocol watch
    always @(posedge clock) begin
        if (!reset) begin
            assert (!wb.stb || wb.cyc) else begin
                $display("Wishbone stb was high without cyc");
                stopWithFailure();
            end
            assert (!(afterAck && wb.stb)) else begin
                $display("Wishbone stb did not drop after an ack");
                stopWithFailure();
            end
        end
        afterAck <= wbAck && !reset;
    end

    // One table entry: request, check, wait out a refill, check again
    task automatic readAndCheck(input int entry);
        ICachePkg::Access request;
        logic             expectHit;
        int               firstBus;
        int               waitCycles;
        string            name;
        request   = testTable[entry].access;
        name      = testNames[entry];
        expectHit = shadowValid[request.index] && (shadowTag[request.index] == request.tag);
        assert (expectHit == testTable[entry].hit) else begin
            $display("Table entry %0d disagrees with the shadow cache", entry);
            stopWithFailure();
        end
        firstBus = busAddresses.size();
        @(posedge clock);
        rd      <= 1'b1;
        address <= ICachePkg::Address'(request);
        @(negedge clock);
        checkValue({name, " busy"}, 32'd0, ICachePkg::Word'(busy));
        checkValue({name, " hit"}, ICachePkg::Word'(expectHit), ICachePkg::Word'(hit));
        if (expectHit) begin
            checkValue({name, " data"}, memoryWord(ICachePkg::Address'(request)), data);
            // A cycle later the hit must not have started a refill
            @(negedge clock);
            checkValue({name, " busy after hit"}, 32'd0, ICachePkg::Word'(busy));
            checkValue({name, " cyc"}, 32'd0, ICachePkg::Word'(wb.cyc));
            checkValue({name, " bus transfers"}, 32'd0, busAddresses.size() - firstBus);
        end else begin
            waitCycles = 0;
            @(negedge clock);
            while (busy) begin
                waitCycles++;
                if (waitCycles > 200) begin
                    $display("Timeout waiting for the refill of %s", name);
                    stopWithFailure();
                end
                @(negedge clock);
            end
            // Same request again, now from the filled line
            checkValue({name, " refill hit"}, 32'd1, ICachePkg::Word'(hit));
            checkValue({name, " refill data"}, memoryWord(ICachePkg::Address'(request)), data);
            checkValue({name, " bus transfers"}, 32'd4, busAddresses.size() - firstBus);
            for (int k = 0; k < 4; k++) begin
                checkValue({name, " bus address"},
                    ICachePkg::Word'(ICachePkg::Address'(
                        {request.tag, request.index, ICachePkg::Offset'(k)})),
                    ICachePkg::Word'(busAddresses[firstBus + k]));
            end
            shadowValid[request.index] = 1'b1;
            shadowTag[request.index]   = request.tag;
        end
        @(posedge clock);
        rd <= 1'b0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        reset   = 1'b1;
        rd      = 1'b0;
        address = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // Reset plus clear sweep keeps the cache busy
        busyCycles = 0;
        @(negedge clock);
        while (busy) begin
            checkValue("reset hit", 32'd0, ICachePkg::Word'(hit));
            checkValue("reset cyc", 32'd0, ICachePkg::Word'(wb.cyc));
            busyCycles++;
            if (busyCycles > 200) begin
                $display("Timeout waiting for busy to fall after reset");
                stopWithFailure();
            end
            @(negedge clock);
        end
        checkValue("reset busy cycles", 32'd33, busyCycles);

        for (int i = 0; i < `ICACHE_LINES; i++) begin
            shadowValid[i] = 1'b0;
            shadowTag[i]   = '0;
        end

        for (int entry = 0; entry < 12; entry++)
            readAndCheck(entry);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
ICachePkg.sv
ICacheController.sv
ICacheStorage.sv
ICacheMemPort.sv
ICache.sv
ICacheTb.sv

//--- run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

LOG=sim.log

verilator --binary --assert -f files.f --top-module ICacheTb -o ICacheTb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/ICacheTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -q "NO ERRORS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
